//--- all.f
src/queue_cfg_pkg.sv
src/queue_cmd_pkg.sv
src/queue_cmd_decode.sv
src/queue_list_engine.sv
src/queue_result_stage.sv
src/queue_manager.sv
testbench/tb_queue_manager.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f all.f \
  --top-module tb_queue_manager \
  -o tb_queue_manager

out="$(./obj_dir/tb_queue_manager || true)"
echo "$out"

if grep -qF '** PASS **' <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- testbench/tb_queue_manager.sv
`timescale 1ns/1ps

module tb_queue_manager;

  localparam int clk_period   = 8;
  localparam int num_directed = 100; // Upper bound of directed cycles.
  localparam int num_random   = 400;

  typedef logic [queue_cfg_pkg::queue_w-1:0] qid_t;
  typedef logic [queue_cfg_pkg::ptr_w-1:0]   ptr_t;
  typedef logic [queue_cfg_pkg::count_w-1:0] cnt_t;
  typedef logic [queue_cfg_pkg::data_w-1:0]  data_t;

  logic                     clk;
  logic                     arst_n;
  logic                     cmd_valid;
  logic [1:0]               cmd_op;
  qid_t                     cmd_queue;
  ptr_t                     cmd_ptr;
  data_t                    cmd_data;
  logic                     rsp_valid;
  logic [1:0]               rsp_op;
  queue_cmd_pkg::rsp_word_t rsp_word;

  // Reference state.
  ptr_t  m_head  [queue_cfg_pkg::num_queues];
  ptr_t  m_tail  [queue_cfg_pkg::num_queues];
  cnt_t  m_count [queue_cfg_pkg::num_queues];
  ptr_t  m_link  [queue_cfg_pkg::num_ptrs];
  logic  m_lvld  [queue_cfg_pkg::num_ptrs];
  data_t m_data  [queue_cfg_pkg::num_ptrs];

  // Expected responses in command order.
  queue_cmd_pkg::rsp_word_t exp_word[$];
  logic [1:0]               exp_op[$];
  int                       exp_cyc[$];
  int                       free_list[$];
  int                       cyc = 0;

  queue_manager i_queue_manager (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_queue (cmd_queue),
    .cmd_ptr   (cmd_ptr),
    .cmd_data  (cmd_data),
    .rsp_valid (rsp_valid),
    .rsp_op    (rsp_op),
    .rsp_word  (rsp_word)
  );

  always #(clk_period / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("[FAIL] %0t: %s got %h, expected %h", $time, what, got, exp));
    end
  endtask

  // Expected response, and the state change the command causes.
  function automatic queue_cmd_pkg::rsp_word_t model_cmd(logic [1:0] op, qid_t q,
                                                         ptr_t ptr, data_t d);
    queue_cmd_pkg::rsp_word_t w;
    ptr_t                     h;
    w = '0;
    if (op == queue_cmd_pkg::op_push) begin
      w.qview.empty = (m_count[q] == '0);
      w.qview.count = m_count[q];
      w.qview.head  = ptr;
      w.qview.data  = d;
      m_data[ptr] = d;
      m_lvld[ptr] = 1'b0;
      if (m_count[q] == '0) begin
        m_head[q] = ptr;
      end else begin
        m_link[m_tail[q]] = ptr;
        m_lvld[m_tail[q]] = 1'b1;
      end
      m_tail[q]  = ptr;
      m_count[q] = m_count[q] + 1'b1;
    end else if (op == queue_cmd_pkg::op_pop) begin
      if (m_count[q] == '0) begin
        w.qview.empty = 1'b1; // Nothing else changes.
      end else begin
        h = m_head[q];
        w.qview.count = m_count[q];
        w.qview.head  = h;
        w.qview.data  = m_data[h];
        m_head[q]  = m_link[h];
        m_count[q] = m_count[q] - 1'b1;
      end
    end else begin
      w.lview.link_valid = m_lvld[ptr];
      w.lview.next       = m_link[ptr];
      w.lview.data       = m_data[ptr];
    end
    return w;
  endfunction

  task automatic send_cmd(logic [1:0] op, qid_t q, ptr_t ptr, data_t d);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_queue = q;
    cmd_ptr   = ptr;
    cmd_data  = d;
    if (op != queue_cmd_pkg::op_reserved) begin
      exp_word.push_back(model_cmd(op, q, ptr, d));
      exp_op.push_back(op);
      exp_cyc.push_back(cyc + queue_cmd_pkg::rsp_latency);
    end
  endtask

  task automatic push_cmd(qid_t q, ptr_t ptr);
    send_cmd(queue_cmd_pkg::op_push, q, ptr, data_t'($urandom));
  endtask

  task automatic pop_cmd(qid_t q);
    send_cmd(queue_cmd_pkg::op_pop, q, ptr_t'($urandom), data_t'($urandom));
  endtask

  task automatic peek_cmd(ptr_t ptr);
    send_cmd(queue_cmd_pkg::op_peek, qid_t'($urandom), ptr, data_t'($urandom));
  endtask

  task automatic reserved_cmd();
    send_cmd(queue_cmd_pkg::op_reserved, qid_t'($urandom), ptr_t'($urandom),
             data_t'($urandom));
  endtask

  // Compares each response against the oldest expectation.
  always @(negedge clk) begin
    if (arst_n) begin
      if (rsp_valid) begin
        if (exp_op.size() == 0) begin
          stop_run("A response arrived while no command was pending.");
        end else begin
          check_value("response cycle", 32'(cyc), 32'(exp_cyc[0]));
          check_value("rsp_op", 32'(rsp_op), 32'(exp_op[0]));
          check_value("rsp_word", 32'(rsp_word), 32'(exp_word[0]));
          void'(exp_word.pop_front());
          void'(exp_op.pop_front());
          void'(exp_cyc.pop_front());
        end
      end else if (exp_op.size() != 0 && exp_cyc[0] <= cyc) begin
        stop_run("A pending command got no response in time.");
      end
    end
  end

  initial begin
    #((4 + num_directed + num_random + queue_cmd_pkg::rsp_latency) * clk_period + 200);
    stop_run($sformatf("Timeout: the run did not finish, %0d responses still pending.",
                       exp_op.size()));
  end

  initial begin
    int r;
    int idx;
    qid_t q;
    void'($urandom(32'h1ee0_9170));
    clk       = 1'b0;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = '0;
    cmd_queue = '0;
    cmd_ptr   = '0;
    cmd_data  = '0;
    for (int i = 0; i < queue_cfg_pkg::num_queues; i++) begin
      m_head[i]  = '0;
      m_tail[i]  = '0;
      m_count[i] = '0;
    end
    for (int i = 0; i < queue_cfg_pkg::num_ptrs; i++) begin
      m_link[i] = '0;
      m_lvld[i] = 1'b0;
      m_data[i] = '0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    repeat (10) @(negedge clk); // Idle with no response allowed.

    // Touch every pointer so each link and data word is known.
    for (int i = 0; i < queue_cfg_pkg::num_ptrs; i++) push_cmd(qid_t'(0), ptr_t'(i));
    for (int i = 0; i < queue_cfg_pkg::num_ptrs; i++) pop_cmd(qid_t'(0));
    push_cmd(qid_t'(0), ptr_t'(15));
    push_cmd(qid_t'(0), ptr_t'(0));
    pop_cmd(qid_t'(0));
    pop_cmd(qid_t'(0));

    // Several queues, popped in push order.
    for (int i = 1; i <= 9; i++) push_cmd(qid_t'(i % 3 + 1), ptr_t'(i));
    for (int k = 0; k < 3; k++) begin
      for (int j = 1; j <= 3; j++) pop_cmd(qid_t'(j));
    end

    pop_cmd(qid_t'(2)); // Empty queue.
    push_cmd(qid_t'(2), ptr_t'(4));
    pop_cmd(qid_t'(2));

    // Links seen by peek.
    push_cmd(qid_t'(3), ptr_t'(5));
    push_cmd(qid_t'(3), ptr_t'(6));
    push_cmd(qid_t'(3), ptr_t'(7));
    peek_cmd(ptr_t'(5));
    peek_cmd(ptr_t'(6));
    peek_cmd(ptr_t'(7));
    for (int k = 0; k < 3; k++) pop_cmd(qid_t'(3));

    push_cmd(qid_t'(1), ptr_t'(2));
    reserved_cmd();
    push_cmd(qid_t'(1), ptr_t'(3));
    reserved_cmd();
    pop_cmd(qid_t'(1));
    reserved_cmd();
    pop_cmd(qid_t'(1));

    // Random back-to-back mix; all queues are empty here.
    for (int i = 0; i < queue_cfg_pkg::num_ptrs; i++) free_list.push_back(i);
    for (int n = 0; n < num_random; n++) begin
      r = $urandom % 10;
      q = qid_t'($urandom);
      if (r < 4 && free_list.size() != 0) begin
        idx = $urandom % free_list.size();
        push_cmd(q, ptr_t'(free_list[idx]));
        free_list.delete(idx);
      end else if (r < 7) begin
        if (m_count[q] != '0) free_list.push_back(int'(m_head[q]));
        pop_cmd(q);
      end else if (r < 9) begin
        peek_cmd(ptr_t'($urandom));
      end else begin
        reserved_cmd();
      end
    end

    @(negedge clk);
    cmd_valid = 1'b0;
    repeat (queue_cmd_pkg::rsp_latency + 2) @(negedge clk);
    if (exp_op.size() != 0) begin
      stop_run($sformatf("%0d expected responses never arrived.", exp_op.size()));
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

//--- src/queue_manager.sv
`timescale 1ns/1ps

module queue_manager (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              cmd_valid,
  input  logic [1:0]                        cmd_op,
  input  logic [queue_cfg_pkg::queue_w-1:0] cmd_queue,
  input  logic [queue_cfg_pkg::ptr_w-1:0]   cmd_ptr,
  input  logic [queue_cfg_pkg::data_w-1:0]  cmd_data,
  output logic                              rsp_valid,
  output logic [1:0]                        rsp_op,
  output queue_cmd_pkg::rsp_word_t          rsp_word
);

  // Decode to engine.
  logic                              do_push;
  logic                              do_pop;
  logic                              do_peek;
  logic [queue_cfg_pkg::queue_w-1:0] op_queue;
  logic [queue_cfg_pkg::ptr_w-1:0]   op_ptr;
  logic [queue_cfg_pkg::data_w-1:0]  op_data;

  // Engine to result stage.
  logic                              ex_valid;
  logic [1:0]                        ex_op;
  logic                              ex_empty;
  logic [queue_cfg_pkg::count_w-1:0] ex_count;
  logic                              ex_link_valid;
  logic [queue_cfg_pkg::ptr_w-1:0]   ex_ptr;
  logic [queue_cfg_pkg::data_w-1:0]  ex_data;

  queue_cmd_decode i_queue_cmd_decode (
    .clk       (clk),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_op    (cmd_op),
    .cmd_queue (cmd_queue),
    .cmd_ptr   (cmd_ptr),
    .cmd_data  (cmd_data),
    .do_push   (do_push),
    .do_pop    (do_pop),
    .do_peek   (do_peek),
    .op_queue  (op_queue),
    .op_ptr    (op_ptr),
    .op_data   (op_data)
  );

  queue_list_engine i_queue_list_engine (
    .clk           (clk),
    .arst_n        (arst_n),
    .do_push       (do_push),
    .do_pop        (do_pop),
    .do_peek       (do_peek),
    .op_queue      (op_queue),
    .op_ptr        (op_ptr),
    .op_data       (op_data),
    .ex_valid      (ex_valid),
    .ex_op         (ex_op),
    .ex_empty      (ex_empty),
    .ex_count      (ex_count),
    .ex_link_valid (ex_link_valid),
    .ex_ptr        (ex_ptr),
    .ex_data       (ex_data)
  );

  queue_result_stage i_queue_result_stage (
    .clk           (clk),
    .arst_n        (arst_n),
    .ex_valid      (ex_valid),
    .ex_op         (ex_op),
    .ex_empty      (ex_empty),
    .ex_count      (ex_count),
    .ex_link_valid (ex_link_valid),
    .ex_ptr        (ex_ptr),
    .ex_data       (ex_data),
    .rsp_valid     (rsp_valid),
    .rsp_op        (rsp_op),
    .rsp_word      (rsp_word)
  );

endmodule

//--- src/queue_result_stage.sv
`timescale 1ns/1ps

module queue_result_stage (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              ex_valid,
  input  logic [1:0]                        ex_op,
  input  logic                              ex_empty,
  input  logic [queue_cfg_pkg::count_w-1:0] ex_count,
  input  logic                              ex_link_valid,
  input  logic [queue_cfg_pkg::ptr_w-1:0]   ex_ptr,
  input  logic [queue_cfg_pkg::data_w-1:0]  ex_data,
  output logic                              rsp_valid,
  output logic [1:0]                        rsp_op,
  output queue_cmd_pkg::rsp_word_t          rsp_word
);

  queue_cmd_pkg::rsp_word_t word_nxt;

  always_comb begin
    word_nxt = '0;
    if (ex_op == queue_cmd_pkg::op_peek) begin
      word_nxt.lview.link_valid = ex_link_valid;
      word_nxt.lview.pad        = '0;
      word_nxt.lview.next       = ex_ptr;
      word_nxt.lview.data       = ex_data;
    end else begin
      word_nxt.qview.empty = ex_empty;
      word_nxt.qview.count = ex_count;
      word_nxt.qview.head  = ex_ptr;
      word_nxt.qview.data  = ex_data;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    rsp_op   <= ex_op;
    rsp_word <= word_nxt;
  end

endmodule

//--- src/queue_list_engine.sv
`timescale 1ns/1ps

module queue_list_engine (
  input  logic                              clk,
  input  logic                              arst_n,
  input  logic                              do_push,
  input  logic                              do_pop,
  input  logic                              do_peek,
  input  logic [queue_cfg_pkg::queue_w-1:0] op_queue,
  input  logic [queue_cfg_pkg::ptr_w-1:0]   op_ptr,
  input  logic [queue_cfg_pkg::data_w-1:0]  op_data,
  output logic                              ex_valid,
  output logic [1:0]                        ex_op,
  output logic                              ex_empty,
  output logic [queue_cfg_pkg::count_w-1:0] ex_count,
  output logic                              ex_link_valid,
  output logic [queue_cfg_pkg::ptr_w-1:0]   ex_ptr,
  output logic [queue_cfg_pkg::data_w-1:0]  ex_data
);

  // Per-queue state.
  logic [queue_cfg_pkg::ptr_w-1:0]   head_q  [queue_cfg_pkg::num_queues];
  logic [queue_cfg_pkg::ptr_w-1:0]   tail_q  [queue_cfg_pkg::num_queues];
  logic [queue_cfg_pkg::count_w-1:0] count_q [queue_cfg_pkg::num_queues];

  // Per-pointer link and data store.
  logic [queue_cfg_pkg::ptr_w-1:0]  link_mem [queue_cfg_pkg::num_ptrs];
  logic [queue_cfg_pkg::data_w-1:0] data_mem [queue_cfg_pkg::num_ptrs];
  logic [queue_cfg_pkg::num_ptrs-1:0] link_vld;

  logic [queue_cfg_pkg::ptr_w-1:0]   cur_head;
  logic [queue_cfg_pkg::ptr_w-1:0]   cur_tail;
  logic [queue_cfg_pkg::count_w-1:0] cur_count;
  logic                              q_empty;

  logic                              empty_nxt;
  logic [queue_cfg_pkg::count_w-1:0] count_nxt;
  logic                              link_valid_nxt;
  logic [queue_cfg_pkg::ptr_w-1:0]   ptr_nxt;
  logic [queue_cfg_pkg::data_w-1:0]  data_nxt;

  assign cur_head  = head_q[op_queue];
  assign cur_tail  = tail_q[op_queue];
  assign cur_count = count_q[op_queue];
  assign q_empty   = (cur_count == '0);

  always_comb begin
    empty_nxt      = 1'b0;
    count_nxt      = '0;
    link_valid_nxt = 1'b0;
    ptr_nxt        = '0;
    data_nxt       = '0;
    if (do_push) begin
      empty_nxt = q_empty;
      count_nxt = cur_count; // Count before the push.
      ptr_nxt   = op_ptr;
      data_nxt  = op_data;
    end else if (do_pop) begin
      if (q_empty) begin
        empty_nxt = 1'b1;
      end else begin
        count_nxt = cur_count;
        ptr_nxt   = cur_head;
        data_nxt  = data_mem[cur_head];
      end
    end else if (do_peek) begin
      link_valid_nxt = link_vld[op_ptr];
      ptr_nxt        = link_mem[op_ptr];
      data_nxt       = data_mem[op_ptr];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < queue_cfg_pkg::num_queues; i++) begin
        head_q[i]  <= '0;
        tail_q[i]  <= '0;
        count_q[i] <= '0;
      end
      link_vld <= '0;
    end else begin
      if (do_push) begin
        link_vld[op_ptr] <= 1'b0; // New tail has no successor.
        if (q_empty) begin
          head_q[op_queue] <= op_ptr;
        end else begin
          link_vld[cur_tail] <= 1'b1;
        end
        tail_q[op_queue]  <= op_ptr;
        count_q[op_queue] <= cur_count + 1'b1;
      end
      if (do_pop && !q_empty) begin
        head_q[op_queue]  <= link_mem[cur_head];
        count_q[op_queue] <= cur_count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      data_mem[op_ptr] <= op_data;
      if (!q_empty) begin
        link_mem[cur_tail] <= op_ptr; // Chain behind the old tail.
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= do_push | do_pop | do_peek;
    end
  end

  // Opcode rebuilt from the one-hot strobes.
  always_ff @(posedge clk) begin
    ex_op         <= {do_peek, do_pop};
    ex_empty      <= empty_nxt;
    ex_count      <= count_nxt;
    ex_link_valid <= link_valid_nxt;
    ex_ptr        <= ptr_nxt;
    ex_data       <= data_nxt;
  end

endmodule

//--- src/queue_cmd_decode.sv
`timescale 1ns/1ps

module queue_cmd_decode (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             cmd_valid,
  input  logic [1:0]                       cmd_op,
  input  logic [queue_cfg_pkg::queue_w-1:0] cmd_queue,
  input  logic [queue_cfg_pkg::ptr_w-1:0]   cmd_ptr,
  input  logic [queue_cfg_pkg::data_w-1:0]  cmd_data,
  output logic                             do_push,
  output logic                             do_pop,
  output logic                             do_peek,
  output logic [queue_cfg_pkg::queue_w-1:0] op_queue,
  output logic [queue_cfg_pkg::ptr_w-1:0]   op_ptr,
  output logic [queue_cfg_pkg::data_w-1:0]  op_data
);

  logic push_nxt;
  logic pop_nxt;
  logic peek_nxt;

  always_comb begin
    push_nxt = 1'b0;
    pop_nxt  = 1'b0;
    peek_nxt = 1'b0;
    if (cmd_valid) begin
      case (cmd_op)
        queue_cmd_pkg::op_push:     push_nxt = 1'b1;
        queue_cmd_pkg::op_pop:      pop_nxt  = 1'b1;
        queue_cmd_pkg::op_peek:     peek_nxt = 1'b1;
        queue_cmd_pkg::op_reserved: ; // Dropped, no response.
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      do_push <= 1'b0;
      do_pop  <= 1'b0;
      do_peek <= 1'b0;
    end else begin
      do_push <= push_nxt;
      do_pop  <= pop_nxt;
      do_peek <= peek_nxt;
    end
  end

  always_ff @(posedge clk) begin
    op_queue <= cmd_queue;
    op_ptr   <= cmd_ptr;
    op_data  <= cmd_data;
  end

endmodule

//--- src/queue_cmd_pkg.sv
package queue_cmd_pkg;

  localparam logic [1:0] op_push     = 2'd0;
  localparam logic [1:0] op_pop      = 2'd1;
  localparam logic [1:0] op_peek     = 2'd2;
  localparam logic [1:0] op_reserved = 2'd3;

  // Decode, engine and result stage.
  localparam int rsp_latency = 3;

  // Push and pop view.
  typedef struct packed {
    logic                              empty;
    logic [queue_cfg_pkg::count_w-1:0] count;
    logic [queue_cfg_pkg::ptr_w-1:0]   head;
    logic [queue_cfg_pkg::data_w-1:0]  data;
  } queue_view_t;

  // Peek view.
  typedef struct packed {
    logic                              link_valid;
    logic [queue_cfg_pkg::count_w-1:0] pad;
    logic [queue_cfg_pkg::ptr_w-1:0]   next;
    logic [queue_cfg_pkg::data_w-1:0]  data;
  } link_view_t;

  typedef union packed {
    queue_view_t qview;
    link_view_t  lview;
  } rsp_word_t;

endpackage

//--- src/queue_cfg_pkg.sv
package queue_cfg_pkg;

  // Queue space.
  localparam int num_queues = 4;
  localparam int queue_w    = 2;

  // Pointer space shared by all queues.
  localparam int num_ptrs = 16;
  localparam int ptr_w    = 4;

  // Holds 0 to num_ptrs.
  localparam int count_w = 5;

  // Entry payload.
  localparam int data_w = 16;

endpackage
